// File: lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data and address width, fixed by rv32
`define LSU_XLEN 32

// destination register index width
`define LSU_REG_AW 5

// clint timer word addresses
// mtime low and high words
`define LSU_MTIME_LO 32'h0200_bff8
`define LSU_MTIME_HI 32'h0200_bffc

// mtimecmp low and high words
`define LSU_MTIMECMP_LO 32'h0200_4000
`define LSU_MTIMECMP_HI 32'h0200_4004

`endif

// File: lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // memory operation code from the pipeline
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8,
        MEM_LR_W = 4'd9,
        MEM_SC_W = 4'd10,
        MEM_AMO  = 4'd11
    } mem_op_e;

    // amo sub-operation, only meaningful with MEM_AMO
    typedef enum logic [3:0] {
        AMO_SWAP = 4'd0,
        AMO_ADD  = 4'd1,
        AMO_XOR  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        AMO_MIN  = 4'd5,
        AMO_MAX  = 4'd6,
        AMO_MINU = 4'd7,
        AMO_MAXU = 4'd8
    } amo_op_e;

    // one instruction, addr carries the alu result
    typedef struct packed {
        mem_op_e                 op;
        amo_op_e                 amo_op;
        logic [`LSU_XLEN-1:0]    addr;
        logic [`LSU_XLEN-1:0]    wdata;
        logic [`LSU_REG_AW-1:0]  rd_idx;
    } lsu_req_t;

    // decoded access kind
    // size_log: 0 byte, 1 half, 2 word
    typedef struct packed {
        logic       is_load;
        logic       is_store;
        logic       is_lr;
        logic       is_sc;
        logic       is_amo;
        logic [1:0] size_log;
        logic       is_signed;
    } lsu_dec_t;

    // single bus beat
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        logic                   we;
        logic [`LSU_XLEN/8-1:0] be;
        logic [`LSU_XLEN-1:0]   wdata;
    } bus_req_t;

    // writeback result
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   rdata;
        logic [`LSU_REG_AW-1:0] rd_idx;
        logic                   misalign;
    } lsu_resp_t;

endpackage

// File: lsu_decode.sv
module lsu_decode (
    input  lsu_pkg::mem_op_e  op_i,
    output lsu_pkg::lsu_dec_t dec_o
);

    always_comb begin
        // unknown codes and NONE fall through as no access
        dec_o = '0;
        case (op_i)
            lsu_pkg::MEM_LB: begin
                dec_o.is_load   = 1'b1;
                dec_o.is_signed = 1'b1;
            end
            lsu_pkg::MEM_LBU: begin
                dec_o.is_load = 1'b1;
            end
            lsu_pkg::MEM_LH: begin
                dec_o.is_load   = 1'b1;
                dec_o.size_log  = 2'd1;
                dec_o.is_signed = 1'b1;
            end
            lsu_pkg::MEM_LHU: begin
                dec_o.is_load  = 1'b1;
                dec_o.size_log = 2'd1;
            end
            lsu_pkg::MEM_LW: begin
                dec_o.is_load  = 1'b1;
                dec_o.size_log = 2'd2;
            end
            lsu_pkg::MEM_SB: begin
                dec_o.is_store = 1'b1;
            end
            lsu_pkg::MEM_SH: begin
                dec_o.is_store = 1'b1;
                dec_o.size_log = 2'd1;
            end
            lsu_pkg::MEM_SW: begin
                dec_o.is_store = 1'b1;
                dec_o.size_log = 2'd2;
            end
            // atomics are always word sized
            lsu_pkg::MEM_LR_W: begin
                dec_o.is_lr    = 1'b1;
                dec_o.size_log = 2'd2;
            end
            lsu_pkg::MEM_SC_W: begin
                dec_o.is_sc    = 1'b1;
                dec_o.size_log = 2'd2;
            end
            lsu_pkg::MEM_AMO: begin
                dec_o.is_amo   = 1'b1;
                dec_o.size_log = 2'd2;
            end
            default: begin
                dec_o = '0;
            end
        endcase
    end

endmodule

// File: lsu_lane.sv
`include "lsu_defines.svh"

module lsu_lane (
    input  logic [`LSU_XLEN-1:0]   addr_i,
    input  lsu_pkg::lsu_dec_t      dec_i,
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    input  logic [`LSU_XLEN-1:0]   rdata_i,
    output logic [`LSU_XLEN/8-1:0] be_o,
    output logic [`LSU_XLEN-1:0]   wdata_o,
    output logic [`LSU_XLEN-1:0]   rdata_o
);

    // byte offset inside the word
    logic [1:0]               ofs;
    logic [`LSU_XLEN/8-1:0]   be_base;
    // read word with the addressed lane moved to bit 0
    logic [`LSU_XLEN-1:0]     rd_shift;
    logic                     sign_b;
    logic                     sign_h;

    assign ofs = addr_i[1:0];

    // unshifted mask from access size
    always_comb begin
        case (dec_i.size_log)
            2'd0:    be_base = 4'b0001;
            2'd1:    be_base = 4'b0011;
            default: be_base = 4'b1111;
        endcase
    end

    assign be_o = be_base << ofs;

    // store data into its lanes, offset times eight
    assign wdata_o = wdata_i << {ofs, 3'b000};

    assign rd_shift = rdata_i >> {ofs, 3'b000};

    // sign bits only when the op asks for it
    assign sign_b = dec_i.is_signed & rd_shift[7];
    assign sign_h = dec_i.is_signed & rd_shift[15];

    always_comb begin
        case (dec_i.size_log)
            2'd0:    rdata_o = {{(`LSU_XLEN-8){sign_b}}, rd_shift[7:0]};
            2'd1:    rdata_o = {{(`LSU_XLEN-16){sign_h}}, rd_shift[15:0]};
            // word, untouched
            default: rdata_o = rdata_i;
        endcase
    end

endmodule

// File: lsu_amo_alu.sv
`include "lsu_defines.svh"

module lsu_amo_alu (
    input  lsu_pkg::amo_op_e     op_i,
    input  logic [`LSU_XLEN-1:0] mem_val_i,
    input  logic [`LSU_XLEN-1:0] src_i,
    output logic [`LSU_XLEN-1:0] result_o
);

    // old memory value below rs2
    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(mem_val_i) < $signed(src_i);
    assign lt_u = mem_val_i < src_i;

    always_comb begin
        case (op_i)
            lsu_pkg::AMO_SWAP: result_o = src_i;
            lsu_pkg::AMO_ADD:  result_o = mem_val_i + src_i;
            lsu_pkg::AMO_XOR:  result_o = mem_val_i ^ src_i;
            lsu_pkg::AMO_AND:  result_o = mem_val_i & src_i;
            lsu_pkg::AMO_OR:   result_o = mem_val_i | src_i;
            // min/max keep the smaller or larger operand
            lsu_pkg::AMO_MIN:  result_o = lt_s ? mem_val_i : src_i;
            lsu_pkg::AMO_MAX:  result_o = lt_s ? src_i : mem_val_i;
            lsu_pkg::AMO_MINU: result_o = lt_u ? mem_val_i : src_i;
            lsu_pkg::AMO_MAXU: result_o = lt_u ? src_i : mem_val_i;
            // unknown op behaves like swap
            default:           result_o = src_i;
        endcase
    end

endmodule

// File: lsu_seq.sv
`include "lsu_defines.svh"

module lsu_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  lsu_pkg::lsu_req_t      req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output lsu_pkg::lsu_req_t      held_req_o,
    input  lsu_pkg::lsu_dec_t      dec_i,
    input  logic [`LSU_XLEN/8-1:0] be_i,
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    input  logic [`LSU_XLEN-1:0]   ext_rdata_i,
    output logic [`LSU_XLEN-1:0]   lane_rdata_o,
    output lsu_pkg::lsu_resp_t     resp_o,
    output logic                   resp_valid_o,
    output lsu_pkg::bus_req_t      mem_o,
    output logic                   mem_valid_o,
    input  logic                   mem_ack_i,
    input  logic [`LSU_XLEN-1:0]   mem_rdata_i,
    output lsu_pkg::bus_req_t      clint_o,
    output logic                   clint_valid_o,
    input  logic                   clint_ack_i,
    input  logic [`LSU_XLEN-1:0]   clint_rdata_i
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_READ, ST_CALC, ST_WRITE, ST_RESP
    } state_e;

    state_e               state_q;
    state_e               state_d;
    lsu_pkg::lsu_req_t    req_q;
    lsu_pkg::lsu_resp_t   resp_q;
    lsu_pkg::bus_req_t    beat;
    logic [`LSU_XLEN-1:0] amo_q;
    logic [`LSU_XLEN-1:0] alu_res;
    logic [`LSU_XLEN-1:0] res_addr_q;
    logic [`LSU_XLEN-1:0] skip_rdata;
    logic [`LSU_XLEN-1:0] word_addr;
    logic [`LSU_XLEN-1:0] bus_rdata;
    logic                 res_valid_q;
    logic                 accept;
    logic                 in_access;
    logic                 in_atomic;
    logic                 in_sc;
    logic                 in_write;
    logic                 in_misalign;
    logic                 in_skip;
    logic                 in_clear;
    logic                 sc_hit;
    logic                 atomic_q;
    logic                 to_clint;
    logic                 beat_on;
    logic                 bus_ack;
    logic                 rd_done;
    logic                 wr_done;

    assign req_ready_o = state_q == ST_IDLE;
    assign accept      = req_valid_i & req_ready_o;

    // classify the incoming op here since the decode only sees the held copy
    assign in_atomic = req_i.op inside {lsu_pkg::MEM_LR_W, lsu_pkg::MEM_SC_W, lsu_pkg::MEM_AMO};
    assign in_sc     = req_i.op == lsu_pkg::MEM_SC_W;
    assign in_write  = in_sc | (req_i.op inside {lsu_pkg::MEM_SB, lsu_pkg::MEM_SH,
                                                 lsu_pkg::MEM_SW});
    assign in_access = in_atomic | in_write | (req_i.op inside {lsu_pkg::MEM_LB,
                       lsu_pkg::MEM_LBU, lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_LW});
    assign in_misalign = in_atomic & (req_i.addr[1:0] != 2'b00);
    assign sc_hit      = res_valid_q & (res_addr_q == req_i.addr);
    // none, misaligned atomic or failed sc answer without a beat
    assign in_skip     = ~in_access | in_misalign | (in_sc & ~sc_hit);
    // stores, sc and amo drop the reservation
    assign in_clear    = in_write | (req_i.op == lsu_pkg::MEM_AMO);

    always_comb begin
        if (in_misalign) begin
            skip_rdata = '0;
        end else if (in_sc) begin
            skip_rdata = `LSU_XLEN'd1;
        end else begin
            // alu result passes through
            skip_rdata = req_i.addr;
        end
    end

    // timer only for plain accesses
    assign atomic_q  = dec_i.is_lr | dec_i.is_sc | dec_i.is_amo;
    assign word_addr = {req_q.addr[`LSU_XLEN-1:2], 2'b00};
    assign to_clint  = ~atomic_q & ((word_addr == `LSU_MTIME_LO) |
                       (word_addr == `LSU_MTIME_HI) | (word_addr == `LSU_MTIMECMP_LO) |
                       (word_addr == `LSU_MTIMECMP_HI));

    assign beat_on   = (state_q == ST_READ) | (state_q == ST_WRITE);
    assign bus_ack   = to_clint ? clint_ack_i : mem_ack_i;
    assign bus_rdata = to_clint ? clint_rdata_i : mem_rdata_i;
    assign rd_done   = (state_q == ST_READ) & bus_ack;
    assign wr_done   = (state_q == ST_WRITE) & bus_ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = in_skip ? ST_RESP : (in_write ? ST_WRITE : ST_READ);
                end
            end
            ST_READ:  if (bus_ack) state_d = dec_i.is_amo ? ST_CALC : ST_RESP;
            ST_CALC:  state_d = ST_WRITE;
            ST_WRITE: if (bus_ack) state_d = ST_RESP;
            ST_RESP:  state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            res_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept & in_clear) begin
                res_valid_q <= 1'b0;
            end else if (rd_done & dec_i.is_lr) begin
                res_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q           <= req_i;
            resp_q.rd_idx   <= req_i.rd_idx;
            resp_q.misalign <= in_misalign;
            resp_q.rdata    <= skip_rdata;
        end
        if (rd_done & dec_i.is_lr) begin
            res_addr_q <= req_q.addr;
        end
        // word accesses come back unextended so amo keeps the old value here
        if (rd_done) begin
            resp_q.rdata <= ext_rdata_i;
        end
        if (state_q == ST_CALC) begin
            amo_q <= alu_res;
        end
        // sc success and stores return zero
        if (wr_done & ~dec_i.is_amo) begin
            resp_q.rdata <= '0;
        end
    end

    lsu_amo_alu lsu_amo_alu_i (
        .op_i      (req_q.amo_op),
        .mem_val_i (resp_q.rdata),
        .src_i     (req_q.wdata),
        .result_o  (alu_res)
    );

    // aligned word atomics get the full mask and word from the lanes
    // amo writes its computed word instead of rs2
    always_comb begin
        beat.addr  = req_q.addr;
        beat.we    = state_q == ST_WRITE;
        beat.be    = be_i;
        beat.wdata = dec_i.is_amo ? amo_q : wdata_i;
    end

    assign mem_o         = beat;
    assign clint_o       = beat;
    assign mem_valid_o   = beat_on & ~to_clint;
    assign clint_valid_o = beat_on & to_clint;
    assign lane_rdata_o  = bus_rdata;
    assign held_req_o    = req_q;
    assign resp_o        = resp_q;
    assign resp_valid_o  = state_q == ST_RESP;

endmodule

// File: lsu_top.sv
`include "lsu_defines.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_pkg::lsu_req_t    req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output lsu_pkg::lsu_resp_t   resp_o,
    output logic                 resp_valid_o,
    output lsu_pkg::bus_req_t    mem_o,
    output logic                 mem_valid_o,
    input  logic                 mem_ack_i,
    input  logic [`LSU_XLEN-1:0] mem_rdata_i,
    output lsu_pkg::bus_req_t    clint_o,
    output logic                 clint_valid_o,
    input  logic                 clint_ack_i,
    input  logic [`LSU_XLEN-1:0] clint_rdata_i
);

    // request held by the sequencer
    lsu_pkg::lsu_req_t      held_req;
    lsu_pkg::lsu_dec_t      dec;
    logic [`LSU_XLEN/8-1:0] lane_be;
    logic [`LSU_XLEN-1:0]   lane_wdata;
    // raw word in, extracted value out
    logic [`LSU_XLEN-1:0]   raw_rdata;
    logic [`LSU_XLEN-1:0]   ext_rdata;

    lsu_decode lsu_decode_i (
        .op_i  (held_req.op),
        .dec_o (dec)
    );

    lsu_lane lsu_lane_i (
        .addr_i  (held_req.addr),
        .dec_i   (dec),
        .wdata_i (held_req.wdata),
        .rdata_i (raw_rdata),
        .be_o    (lane_be),
        .wdata_o (lane_wdata),
        .rdata_o (ext_rdata)
    );

    lsu_seq lsu_seq_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .held_req_o    (held_req),
        .dec_i         (dec),
        .be_i          (lane_be),
        .wdata_i       (lane_wdata),
        .ext_rdata_i   (ext_rdata),
        .lane_rdata_o  (raw_rdata),
        .resp_o        (resp_o),
        .resp_valid_o  (resp_valid_o),
        .mem_o         (mem_o),
        .mem_valid_o   (mem_valid_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i),
        .clint_o       (clint_o),
        .clint_valid_o (clint_valid_o),
        .clint_ack_i   (clint_ack_i),
        .clint_rdata_i (clint_rdata_i)
    );

endmodule

// File: lsu_props.sv
module lsu_props (
    input logic              clk,
    input logic              rst,
    input lsu_pkg::bus_req_t mem_i,
    input logic              mem_valid_i,
    input logic              mem_ack_i,
    input lsu_pkg::bus_req_t clint_i,
    input logic              clint_valid_i,
    input logic              clint_ack_i,
    input logic              resp_valid_i
);

    // read back by the testbench at the end
    int fail_cnt = 0;

    // beat holds with a fixed payload until acked
    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ack_i |=> mem_valid_i && $stable(mem_i))
        else begin
            $error("memory beat dropped or changed before its ack");
            fail_cnt++;
        end

    clint_hold: assert property (@(posedge clk) disable iff (rst)
        clint_valid_i && !clint_ack_i |=> clint_valid_i && $stable(clint_i))
        else begin
            $error("timer beat dropped or changed before its ack");
            fail_cnt++;
        end

    // only one target at a time
    one_port: assert property (@(posedge clk) disable iff (rst)
        !(mem_valid_i && clint_valid_i))
        else begin
            $error("memory and timer valid high together");
            fail_cnt++;
        end

    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        resp_valid_i |=> !resp_valid_i)
        else begin
            $error("response valid longer than one cycle");
            fail_cnt++;
        end

endmodule

bind lsu_seq lsu_props lsu_props_i (
    .clk           (clk),
    .rst           (rst),
    .mem_i         (mem_o),
    .mem_valid_i   (mem_valid_o),
    .mem_ack_i     (mem_ack_i),
    .clint_i       (clint_o),
    .clint_valid_i (clint_valid_o),
    .clint_ack_i   (clint_ack_i),
    .resp_valid_i  (resp_valid_o)
);

// File: tb_lsu.sv
`include "lsu_defines.svh"

module tb_lsu;

    // number of requests issued, rounded up
    localparam int REQ_BUDGET = 80;
    // every request finishes far below this many cycles
    localparam int CYC_PER_REQ = 40;

    logic                 clk;
    logic                 rst;
    lsu_pkg::lsu_req_t    req_i;
    logic                 req_valid_i;
    logic                 req_ready_o;
    lsu_pkg::lsu_resp_t   resp_o;
    logic                 resp_valid_o;
    lsu_pkg::bus_req_t    mem_o;
    logic                 mem_valid_o;
    logic                 mem_ack_i;
    logic [31:0]          mem_rdata_i;
    lsu_pkg::bus_req_t    clint_o;
    logic                 clint_valid_o;
    logic                 clint_ack_i;
    logic [31:0]          clint_rdata_i;

    // memory and timer models
    logic [31:0]          mem [0:255];
    logic [31:0]          tmr [0:3];
    logic                 mem_busy;
    int                   mem_wait;
    int                   extra_delay;
    int                   seed;
    // last write beat seen by memory
    logic [3:0]           last_be;
    logic [31:0]          last_wdata;
    // last address acked by the timer
    logic [31:0]          clint_addr_seen;

    // result of the latest request
    lsu_pkg::lsu_resp_t   got;
    logic                 saw_mem;
    logic                 saw_clint;
    int                   lat;
    logic [4:0]           rd_next;
    int                   errors;

    lsu_top lsu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fill value mixes every index bit and gives both sign polarities per byte
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx ^ 8'hc3, ~idx, idx ^ 8'h5a, idx + 8'h71};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int j = 0; j < 4; j++) begin
            if (be[j]) res[j*8 +: 8] = data[j*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] tmr_addr(input int k);
        case (k)
            0:       return `LSU_MTIME_LO;
            1:       return `LSU_MTIME_HI;
            2:       return `LSU_MTIMECMP_LO;
            default: return `LSU_MTIMECMP_HI;
        endcase
    endfunction

    function automatic int tmr_idx(input logic [31:0] a);
        for (int k = 0; k < 4; k++) begin
            if (tmr_addr(k) == {a[31:2], 2'b00}) return k;
        end
        return 0;
    endfunction

    // expected load value from the lane rule
    function automatic logic [31:0] load_ref(input lsu_pkg::mem_op_e op,
                                             input logic [31:0] w, input int ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[ofs*8 +: 8];
        h = (ofs >= 2) ? w[31:16] : w[15:0];
        case (op)
            lsu_pkg::MEM_LB:  return {{24{b[7]}}, b};
            lsu_pkg::MEM_LBU: return {24'h0, b};
            lsu_pkg::MEM_LH:  return {{16{h[15]}}, h};
            lsu_pkg::MEM_LHU: return {16'h0, h};
            default:          return w;
        endcase
    endfunction

    // new memory word for each amo op
    function automatic logic [31:0] amo_ref(input lsu_pkg::amo_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            lsu_pkg::AMO_ADD:  return a + b;
            lsu_pkg::AMO_XOR:  return a ^ b;
            lsu_pkg::AMO_AND:  return a & b;
            lsu_pkg::AMO_OR:   return a | b;
            lsu_pkg::AMO_MIN:  return ($signed(a) > $signed(b)) ? b : a;
            lsu_pkg::AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            lsu_pkg::AMO_MINU: return (a > b) ? b : a;
            lsu_pkg::AMO_MAXU: return (a > b) ? a : b;
            default:           return b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got_v,
                         input logic [31:0] exp_v);
        if (got_v !== exp_v) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got_v, exp_v);
        end
    endtask

    // memory acks after 0..3 cycles plus the stall setting
    always @(negedge clk) begin
        if (mem_ack_i) begin
            mem_ack_i = 1'b0;
            mem_busy  = 1'b0;
        end else if (mem_valid_o) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = ($random(seed) & 3) + extra_delay;
            end
            if (mem_wait == 0) begin
                mem_ack_i   = 1'b1;
                mem_rdata_i = mem[mem_o.addr[9:2]];
                if (mem_o.we) begin
                    mem[mem_o.addr[9:2]] = merge_bytes(mem[mem_o.addr[9:2]],
                                                       mem_o.wdata, mem_o.be);
                    last_be    = mem_o.be;
                    last_wdata = mem_o.wdata;
                end
            end else begin
                mem_wait--;
            end
        end
    end

    // timer answers on the first cycle
    always @(negedge clk) begin
        if (clint_ack_i) begin
            clint_ack_i = 1'b0;
        end else if (clint_valid_o) begin
            clint_ack_i     = 1'b1;
            clint_addr_seen = clint_o.addr;
            clint_rdata_i   = tmr[tmr_idx(clint_o.addr)];
            if (clint_o.we) begin
                tmr[tmr_idx(clint_o.addr)] = merge_bytes(tmr[tmr_idx(clint_o.addr)],
                                                         clint_o.wdata, clint_o.be);
            end
        end
    end

    // one request then wait for the pulse while ready stays low
    task automatic issue(input lsu_pkg::mem_op_e op, input lsu_pkg::amo_op_e amo,
                         input logic [31:0] addr, input logic [31:0] wdata);
        req_i.op     = op;
        req_i.amo_op = amo;
        req_i.addr   = addr;
        req_i.wdata  = wdata;
        req_i.rd_idx = rd_next;
        req_valid_i  = 1'b1;
        while (!req_ready_o) @(negedge clk);
        @(negedge clk);
        req_valid_i = 1'b0;
        saw_mem     = 1'b0;
        saw_clint   = 1'b0;
        lat         = 1;
        while (!resp_valid_o) begin
            saw_mem   = saw_mem | mem_valid_o;
            saw_clint = saw_clint | clint_valid_o;
            check("req_ready_o", req_ready_o, 0);
            lat++;
            @(negedge clk);
        end
        check("req_ready_o", req_ready_o, 0);
        got = resp_o;
        check("resp_o.rd_idx", got.rd_idx, rd_next);
        rd_next++;
    endtask

    task automatic load_check(input lsu_pkg::mem_op_e op, input logic [31:0] a);
        logic [31:0] exp_v;
        exp_v = load_ref(op, mem[a[9:2]], a[1:0]);
        issue(op, lsu_pkg::AMO_SWAP, a, 32'h0);
        check("load rdata", got.rdata, exp_v);
        check("load misalign", got.misalign, 0);
        check("load mem_valid_o", saw_mem, 1);
    endtask

    task automatic loads_every_offset();
        logic [31:0] a;
        for (int k = 0; k < 8; k++) begin
            a = 32'h100 + (k / 4) * 4 + (k % 4);
            load_check(lsu_pkg::MEM_LB, a);
            load_check(lsu_pkg::MEM_LBU, a);
            if (a[0] == 1'b0) begin
                load_check(lsu_pkg::MEM_LH, a);
                load_check(lsu_pkg::MEM_LHU, a);
            end
            if (a[1:0] == 2'b00) load_check(lsu_pkg::MEM_LW, a);
        end
    endtask

    task automatic store_check(input lsu_pkg::mem_op_e op, input logic [31:0] a,
                               input logic [31:0] val);
        logic [3:0]  exp_be;
        logic [31:0] exp_data;
        logic [31:0] exp_word;
        int          ofs;
        ofs = a[1:0];
        case (op)
            lsu_pkg::MEM_SB: exp_be = 4'b0001;
            lsu_pkg::MEM_SH: exp_be = 4'b0011;
            default:         exp_be = 4'b1111;
        endcase
        exp_be     = exp_be << ofs;
        exp_data   = val << (8 * ofs);
        exp_word   = merge_bytes(mem[a[9:2]], exp_data, exp_be);
        last_be    = 4'h0;
        last_wdata = 32'h0;
        issue(op, lsu_pkg::AMO_SWAP, a, val);
        check("store mem_valid_o", saw_mem, 1);
        check("mem_o.be", last_be, exp_be);
        check("mem_o.wdata", last_wdata, exp_data);
        // read back so untouched bytes must keep the old value
        issue(lsu_pkg::MEM_LW, lsu_pkg::AMO_SWAP, {a[31:2], 2'b00}, 32'h0);
        check("store readback", got.rdata, exp_word);
    endtask

    task automatic stores_with_readback();
        for (int k = 0; k < 4; k++) begin
            store_check(lsu_pkg::MEM_SB, 32'h140 + k, 32'ha1b2_c3d4 + k);
        end
        store_check(lsu_pkg::MEM_SH, 32'h144, 32'h1357_9bdf);
        store_check(lsu_pkg::MEM_SH, 32'h146, 32'h2468_ace0);
        store_check(lsu_pkg::MEM_SW, 32'h148, 32'hdead_beef);
    endtask

    task automatic timer_steering();
        logic [31:0] a;
        for (int k = 0; k < 4; k++) begin
            a = tmr_addr(k);
            clint_addr_seen = 32'h0;
            issue(lsu_pkg::MEM_LW, lsu_pkg::AMO_SWAP, a, 32'h0);
            check("timer load rdata", got.rdata, tmr[k]);
            check("timer load mem_valid_o", saw_mem, 0);
            check("timer load clint_valid_o", saw_clint, 1);
            check("timer load clint_o.addr", clint_addr_seen, a);
            clint_addr_seen = 32'h0;
            issue(lsu_pkg::MEM_SW, lsu_pkg::AMO_SWAP, a, 32'h5eed_0000 | k);
            check("timer store mem_valid_o", saw_mem, 0);
            check("timer store clint_valid_o", saw_clint, 1);
            check("timer store clint_o.addr", clint_addr_seen, a);
            check("timer register", tmr[k], 32'h5eed_0000 | k);
        end
    endtask

    task automatic lr_sc_sequence();
        logic [31:0] a;
        a = 32'h180;
        issue(lsu_pkg::MEM_LR_W, lsu_pkg::AMO_SWAP, a, 32'h0);
        check("lr rdata", got.rdata, mem[a[9:2]]);
        issue(lsu_pkg::MEM_SC_W, lsu_pkg::AMO_SWAP, a, 32'h0bad_cafe);
        check("sc hit rdata", got.rdata, 0);
        check("sc hit mem_valid_o", saw_mem, 1);
        check("sc hit memory", mem[a[9:2]], 32'h0bad_cafe);
        // reservation is gone now
        issue(lsu_pkg::MEM_SC_W, lsu_pkg::AMO_SWAP, a, 32'h1111_2222);
        check("sc miss rdata", got.rdata, 1);
        check("sc miss mem_valid_o", saw_mem, 0);
        check("sc miss memory", mem[a[9:2]], 32'h0bad_cafe);
        // a plain store in between kills it
        issue(lsu_pkg::MEM_LR_W, lsu_pkg::AMO_SWAP, a, 32'h0);
        issue(lsu_pkg::MEM_SW, lsu_pkg::AMO_SWAP, a, 32'h7777_0001);
        issue(lsu_pkg::MEM_SC_W, lsu_pkg::AMO_SWAP, a, 32'h7777_0002);
        check("sc after store rdata", got.rdata, 1);
        check("sc after store mem_valid_o", saw_mem, 0);
        check("sc after store memory", mem[a[9:2]], 32'h7777_0001);
    endtask

    task automatic amo_all_ops();
        lsu_pkg::amo_op_e op;
        logic [31:0]      old_v;
        logic [31:0]      src_v;
        for (int k = 0; k < 18; k++) begin
            op = lsu_pkg::amo_op_e'(4'(k % 9));
            // negative old vs small positive and then the reverse
            old_v = (k < 9) ? 32'hffff_fff0 : 32'h0000_0007;
            src_v = (k < 9) ? 32'h0000_0005 : 32'h8000_0003;
            mem[8'h70] = old_v;
            issue(lsu_pkg::MEM_AMO, op, 32'h1c0, src_v);
            check("amo rdata", got.rdata, old_v);
            check("amo memory", mem[8'h70], amo_ref(op, old_v, src_v));
        end
    endtask

    task automatic misalign_and_stall();
        issue(lsu_pkg::MEM_AMO, lsu_pkg::AMO_ADD, 32'h1c2, 32'h1);
        check("amo misalign", got.misalign, 1);
        check("amo misalign rdata", got.rdata, 0);
        check("amo misalign mem_valid_o", saw_mem, 0);
        check("amo misalign clint_valid_o", saw_clint, 0);
        check("amo misalign latency", lat, 1);
        issue(lsu_pkg::MEM_LR_W, lsu_pkg::AMO_SWAP, 32'h182, 32'h0);
        check("lr misalign", got.misalign, 1);
        check("lr misalign mem_valid_o", saw_mem, 0);
        // no access so the alu result comes straight back
        issue(lsu_pkg::MEM_NONE, lsu_pkg::AMO_SWAP, 32'h1234_5678, 32'h0);
        check("none rdata", got.rdata, 32'h1234_5678);
        check("none latency", lat, 1);
        // slow memory
        extra_delay = 8;
        issue(lsu_pkg::MEM_LW, lsu_pkg::AMO_SWAP, 32'h100, 32'h0);
        check("stalled load rdata", got.rdata, mem[8'h40]);
        check("stalled load latency", lat > 9, 1);
        issue(lsu_pkg::MEM_SW, lsu_pkg::AMO_SWAP, 32'h104, 32'hcafe_f00d);
        check("stalled store memory", mem[8'h41], 32'hcafe_f00d);
        extra_delay = 0;
    endtask

    initial begin
        seed            = 17;
        errors          = 0;
        extra_delay     = 0;
        rd_next         = 5'd0;
        mem_busy        = 1'b0;
        mem_wait        = 0;
        clint_addr_seen = 32'h0;
        rst             = 1'b1;
        req_i           = '0;
        req_valid_i     = 1'b0;
        mem_ack_i       = 1'b0;
        mem_rdata_i     = 32'h0;
        clint_ack_i     = 1'b0;
        clint_rdata_i   = 32'h0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i[7:0]);
        for (int k = 0; k < 4; k++) tmr[k] = 32'hc100_0000 | (k * 32'h0001_0203);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("req_ready_o after reset", req_ready_o, 1);
        check("resp_valid_o after reset", resp_valid_o, 0);
        check("mem_valid_o after reset", mem_valid_o, 0);
        check("clint_valid_o after reset", clint_valid_o, 0);
        loads_every_offset();
        stores_with_readback();
        timer_steering();
        lr_sc_sequence();
        amo_all_ops();
        misalign_and_stall();
        @(negedge clk);
        $display("errors: %0d check, %0d assertion", errors,
                 lsu_top_i.lsu_seq_i.lsu_props_i.fail_cnt);
        if (errors == 0 && lsu_top_i.lsu_seq_i.lsu_props_i.fail_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // watchdog
    initial begin
        repeat (5 + REQ_BUDGET * CYC_PER_REQ) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 5 + REQ_BUDGET * CYC_PER_REQ);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_lane.sv
lsu_amo_alu.sv
lsu_seq.sv
lsu_top.sv
lsu_props.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - .

sources:
  - lsu_pkg.sv
  - lsu_decode.sv
  - lsu_lane.sv
  - lsu_amo_alu.sv
  - lsu_seq.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_props.sv
      - tb_lsu.sv
